// ==== sim.f ====
+incdir+source
source/i2s_pkg.sv
source/sck_divider.sv
source/i2s_tx.sv
source/i2s_rx.sv
source/i2s_port.sv
verification/i2s_checker.sv
verification/i2s_port_tb.sv

// ==== Makefile ====
# Verilator build and run of the I2S port regression

LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the regression"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module i2s_port_tb -o i2s_port_sim
	./obj_dir/i2s_port_sim | tee $(LOG)
	@grep -qx "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/i2s_port_tb.sv ====
/*
 * I2S port testbench
 *   clock, reset and random sample pairs after each frame request
 *   transmit pins looped back into the receive pins
 *   one mid-frame change of tx_left
 *   watchdog and closing report
 */

`timescale 1ns/1ps
`include "i2s_settings.svh"

module i2s_port_tb
    import i2s_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DLY       = 5;         // ns after the rising edge
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_FRAMES      = 40;
    localparam int STRESS_FRAME    = 10;        // tx_left moves inside this frame
    localparam int BIT_CYCLES      = 2 * `HALF_SCK_CYCLES;
    localparam int FRAME_CYCLES    = 2 * `SAMPLE_BITS * BIT_CYCLES;
    localparam int WATCHDOG_CYCLES = 42 * FRAME_CYCLES + RESET_CYCLES;
    localparam int PAIR_TIMEOUT    = 2 * BIT_CYCLES;

    logic    clk;
    logic    rst_n;
    sample_t tx_left;
    sample_t tx_right;
    logic    frame_req;
    logic    sck_out;
    logic    ws_out;
    logic    sd_out;
    sample_t rx_left;
    sample_t rx_right;
    logic    rx_valid;
    int      chk_errors;
    int      chk_reqs;
    int      chk_valids;
    int      tb_errors;

    always #(CLK_PERIOD / 2) clk = ~clk;

    i2s_port dut_i
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_left   (tx_left),
        .tx_right  (tx_right),
        .frame_req (frame_req),
        .sck_out   (sck_out),
        .ws_out    (ws_out),
        .sd_out    (sd_out),
        .sck_in    (sck_out),   // loopback
        .ws_in     (ws_out),
        .sd_in     (sd_out),
        .rx_left   (rx_left),
        .rx_right  (rx_right),
        .rx_valid  (rx_valid)
    );

    i2s_checker chk_i
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .tx_left      (tx_left),
        .tx_right     (tx_right),
        .frame_req    (frame_req),
        .sck_out      (sck_out),
        .ws_out       (ws_out),
        .sd_out       (sd_out),
        .rx_left      (rx_left),
        .rx_right     (rx_right),
        .rx_valid     (rx_valid),
        .stress_frame (STRESS_FRAME),
        .error_count  (chk_errors),
        .req_count    (chk_reqs),
        .valid_count  (chk_valids)
    );

    // returns just after the edge that latched the pair
    task automatic wait_frame_req();
        @(negedge clk);
        while (frame_req !== 1'b1)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // halfway through the left word of the frame in flight
    task automatic change_left_mid_frame();
        repeat ((`SAMPLE_BITS / 2) * BIT_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        tx_left = ~tx_left;
        $display("tx_left changed in the middle of frame %0d", STRESS_FRAME);
    endtask

    // receiver publishes the last complete pair soon after the final request
    task automatic collect_last_pair();
        int waited;
        waited = 0;
        while (rx_valid !== 1'b1 && waited < PAIR_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (rx_valid !== 1'b1)
        begin
            $display("no rx_valid within %0d clocks after the last frame request",
                     PAIR_TIMEOUT);
            tb_errors++;
        end
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic report_and_finish();
        int total;
        if (chk_valids != chk_reqs - 2)
        begin
            $display("%0d rx_valid pulses seen for %0d frame requests, expected two fewer",
                     chk_valids, chk_reqs);
            tb_errors++;
        end
        total = chk_errors + tb_errors;
        $display("errors: %0d (checker %0d, testbench %0d)", total, chk_errors, tb_errors);
        if (total == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial
    begin
        void'($urandom(32'h5366_9ede));
        clk       = 1'b0;
        rst_n     = 1'b0;
        tb_errors = 0;
        tx_left   = sample_t'($urandom());
        tx_right  = sample_t'($urandom());

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        for (int f = 0; f < NUM_FRAMES; f++)
        begin
            wait_frame_req();
            tx_left  = sample_t'($urandom());     // pair for the next frame
            tx_right = sample_t'($urandom());
            if (f == STRESS_FRAME)
                change_left_mid_frame();
        end

        // let the last complete pair come out of the receiver
        collect_last_pair();
        report_and_finish();
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d clocks with %0d of %0d frames sent",
                 WATCHDOG_CYCLES, chk_reqs, NUM_FRAMES);
        $display("errors: %0d (checker %0d, testbench %0d)",
                 chk_errors + tb_errors + 1, chk_errors, tb_errors);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== verification/i2s_checker.sv ====
/*
 * I2S port checker
 *   reference function for the serial ws and sd pattern
 *   bit clock phase and reset state checks
 *   frame queue with serial and loopback compares
 */

`timescale 1ns/1ps
`include "i2s_settings.svh"

module i2s_checker
    import i2s_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t tx_left,
    input  sample_t tx_right,
    input  logic    frame_req,
    input  logic    sck_out,
    input  logic    ws_out,
    input  logic    sd_out,
    input  sample_t rx_left,
    input  sample_t rx_right,
    input  logic    rx_valid,
    input  int      stress_frame,
    output int      error_count,
    output int      req_count,
    output int      valid_count
);

    localparam int FRAME_BITS = 2 * `SAMPLE_BITS;

    sample_t    left_q[$];          // pairs the receiver still owes
    sample_t    right_q[$];
    int         frame_q[$];
    sample_t    cur_left;           // pair latched for the frame on the wire
    sample_t    cur_right;
    int         cur_frame;
    int         bit_pos;            // bit periods seen in this frame
    int         phase_len;          // clocks since sck_out last moved
    int         idx;
    bit         sck_prev;
    logic [1:0] exp_line;

    // {ws, sd} for bit pos of a frame, pos 0 is the left MSB
    function automatic logic [1:0] expected_line(input sample_t left, input sample_t right,
                                                 input int pos);
        int      b;
        sample_t word;
        logic    ws;
        b    = pos % `SAMPLE_BITS;
        word = (pos < `SAMPLE_BITS) ? left : right;
        word = word >> (`SAMPLE_BITS - 1 - b);
        // ws high on the last left bit and on right bits 0..14
        ws   = (pos < `SAMPLE_BITS) ? (b == `SAMPLE_BITS - 1) : (b != `SAMPLE_BITS - 1);
        return {ws, word[0]};
    endfunction

    function automatic string test_name(input string base, input int frame);
        if (frame == stress_frame)
            return {"stability_", base};
        return base;
    endfunction

    task automatic check_value(input string test, input int frame, input sample_t expected,
                               input sample_t actual);
        if (actual !== expected)
        begin
            $display("Fail %s frame %0d: expected %h, actual %h", test, frame, expected, actual);
            error_count++;
        end
    endtask

    //////////////////////////////
    // per clock checks
    //////////////////////////////
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (sck_out !== sck_prev)
            begin
                check_value("sck_phase", req_count, sample_t'(`HALF_SCK_CYCLES),
                            sample_t'(phase_len));
                phase_len = 0;
            end
            phase_len++;

            // outputs stay quiet until the first frame opens
            if (req_count == 0 && ({ws_out, sd_out, rx_valid} !== 3'b000 ||
                rx_left !== '0 || rx_right !== '0))
            begin
                $display("outputs left their reset values before the first frame request");
                error_count++;
            end

            // serial line sampled on each bit clock rise
            if (sck_out && !sck_prev && req_count > 0)
            begin
                if (bit_pos < FRAME_BITS)
                begin
                    exp_line = expected_line(cur_left, cur_right, bit_pos);
                    check_value(test_name("serial_ws", cur_frame), cur_frame,
                                sample_t'(exp_line[1]), sample_t'(ws_out));
                    check_value(test_name("serial_sd", cur_frame), cur_frame,
                                sample_t'(exp_line[0]), sample_t'(sd_out));
                end
                bit_pos++;
            end

            if (frame_req)
            begin
                if (req_count > 0 && bit_pos != FRAME_BITS)
                begin
                    $display("frame %0d carried %0d bit periods instead of %0d",
                             cur_frame, bit_pos, FRAME_BITS);
                    error_count++;
                end
                cur_frame = req_count;
                cur_left  = tx_left;
                cur_right = tx_right;
                bit_pos   = 0;
                req_count++;
                if (cur_frame > 0)      // frame 0 has no ws fall ahead of it
                begin
                    left_q.push_back(tx_left);
                    right_q.push_back(tx_right);
                    frame_q.push_back(cur_frame);
                end
            end

            if (rx_valid)
            begin
                valid_count++;
                if (frame_q.size() == 0)
                begin
                    $display("rx_valid pulsed with no transmitted frame waiting for it");
                    error_count++;
                end
                else
                begin
                    idx = frame_q.pop_front();
                    check_value(test_name("loopback_left", idx), idx, left_q.pop_front(), rx_left);
                    check_value(test_name("loopback_right", idx), idx, right_q.pop_front(),
                                rx_right);
                end
            end
            sck_prev = sck_out;
        end
    end

endmodule

// ==== source/i2s_port.sv ====
/*
 * I2S port top level
 *   bit clock divider
 *   transmitter on the divided clock
 *   receiver on the external bit clock
 */

`timescale 1ns/1ps

module i2s_port
    import i2s_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    // transmit side
    input  sample_t tx_left,
    input  sample_t tx_right,
    output logic    frame_req,
    output logic    sck_out,
    output logic    ws_out,
    output logic    sd_out,

    // receive side
    input  logic    sck_in,
    input  logic    ws_in,
    input  logic    sd_in,
    output sample_t rx_left,
    output sample_t rx_right,
    output logic    rx_valid
);

    logic sck_fall;

    //////////////////////////////
    // transmit path
    //////////////////////////////
    sck_divider sck_div_i
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .sck      (sck_out),
        .sck_rise (),               // transmitter only moves on the fall
        .sck_fall (sck_fall)
    );

    i2s_tx tx_i
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .sck_fall  (sck_fall),
        .tx_left   (tx_left),
        .tx_right  (tx_right),
        .ws        (ws_out),
        .sd        (sd_out),
        .frame_req (frame_req)
    );

    //////////////////////////////
    // receive path
    //////////////////////////////
    i2s_rx rx_i
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .sck      (sck_in),
        .ws       (ws_in),
        .sd       (sd_in),
        .rx_left  (rx_left),
        .rx_right (rx_right),
        .rx_valid (rx_valid)
    );

endmodule

// ==== source/i2s_rx.sv ====
/*
 * I2S receiver
 *   two-flop synchronizers on sck, ws and sd
 *   sck rising edge detect
 *   shift register with one-bit-delayed word select
 *   left word hold and pair publish with rx_valid strobe
 */

`timescale 1ns/1ps
`include "i2s_settings.svh"

module i2s_rx
    import i2s_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    sck,
    input  logic    ws,
    input  logic    sd,
    output sample_t rx_left,
    output sample_t rx_right,
    output logic    rx_valid
);

    logic [1:0] sck_sync;
    logic [1:0] ws_sync;
    logic [1:0] sd_sync;
    logic       sck_q;          // previous synchronized sck
    logic       sck_rise;

    logic       ws_d;           // ws of the previous bit
    channel_t   cur_ch;         // channel of the last sampled bit
    channel_t   bit_ch;         // channel of the bit sampled now
    logic       aligned;        // seen a right to left turn since reset

    sample_t    shift_q;
    sample_t    left_hold;      // completed left word
    logic       left_done;
    logic       right_done;

    //////////////////////////////
    // input synchronizers
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sck_sync <= '0;
            ws_sync  <= '0;
            sd_sync  <= '0;
            sck_q    <= 1'b0;
        end
        else
        begin
            sck_sync <= {sck_sync[0], sck};
            ws_sync  <= {ws_sync[0], ws};
            sd_sync  <= {sd_sync[0], sd};
            sck_q    <= sck_sync[1];
        end
    end

    assign sck_rise = sck_sync[1] & ~sck_q;

    //////////////////////////////
    // word boundaries
    //////////////////////////////

    // ws runs one bit ahead, so the delayed copy names this bit's channel
    assign bit_ch = ws_d ? CH_RIGHT : CH_LEFT;

    // shift_q still holds the finished word at these edges
    assign left_done  = sck_rise && (cur_ch == CH_LEFT) && (bit_ch == CH_RIGHT);
    assign right_done = sck_rise && (cur_ch == CH_RIGHT) && (bit_ch == CH_LEFT);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ws_d     <= 1'b0;
            cur_ch   <= CH_LEFT;
            aligned  <= 1'b0;
            rx_left  <= '0;
            rx_right <= '0;
            rx_valid <= 1'b0;
        end
        else
        begin
            rx_valid <= 1'b0;

            if (sck_rise)
            begin
                ws_d   <= ws_sync[1];
                cur_ch <= bit_ch;
            end

            if (right_done)
            begin
                aligned <= 1'b1;            // first turn only aligns
                if (aligned)
                begin
                    rx_left  <= left_hold;
                    rx_right <= shift_q;
                    rx_valid <= 1'b1;
                end
            end
        end
    end

    // deserializer, MSB arrives first
    always_ff @(posedge clk)
    begin
        if (sck_rise)
        begin
            shift_q <= {shift_q[`SAMPLE_BITS-2:0], sd_sync[1]};
        end
        if (left_done)
        begin
            left_hold <= shift_q;
        end
    end

endmodule

// ==== source/i2s_tx.sv ====
/*
 * I2S transmitter
 *   bit index and channel counters advanced on each sck fall
 *   sample pair latched at the start of every frame
 *   registered word select and serial data, MSB first
 *   frame_req strobe in the clock the pair is taken
 */

`timescale 1ns/1ps
`include "i2s_settings.svh"

module i2s_tx
    import i2s_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    sck_fall,
    input  sample_t tx_left,
    input  sample_t tx_right,
    output logic    ws,
    output logic    sd,
    output logic    frame_req
);

    localparam bit_index_t LAST_BIT = bit_index_t'(`SAMPLE_BITS - 1);

    bit_index_t bit_idx;        // next bit to put on the wire
    channel_t   chan;           // channel of that bit
    sample_t    left_q;         // held samples for the frame in flight
    sample_t    right_q;

    logic       frame_start;
    sample_t    cur_word;
    logic       ws_next;
    logic       sd_next;

    //////////////////////////////
    // next bit selection
    //////////////////////////////

    // left MSB is next, so this fall opens a new frame
    assign frame_start = (chan == CH_LEFT) && (bit_idx == '0);
    assign frame_req   = sck_fall && frame_start;

    always_comb
    begin
        if (chan == CH_RIGHT)
        begin
            cur_word = right_q;
        end
        else if (frame_start)
        begin
            cur_word = tx_left;     // held copy not loaded yet
        end
        else
        begin
            cur_word = left_q;
        end
    end

    // ws leads the word by one bit
    // high on right bits 0..14 and on the last left bit
    assign ws_next = (chan == CH_RIGHT) ? (bit_idx != LAST_BIT) : (bit_idx == LAST_BIT);
    assign sd_next = cur_word[LAST_BIT - bit_idx];

    //////////////////////////////
    // serializer counters and outputs
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_idx <= '0;
            chan    <= CH_LEFT;
            ws      <= 1'b0;
            sd      <= 1'b0;
        end
        else if (sck_fall)
        begin
            ws <= ws_next;
            sd <= sd_next;

            if (bit_idx == LAST_BIT)
            begin
                bit_idx <= '0;
                chan    <= (chan == CH_LEFT) ? CH_RIGHT : CH_LEFT;   // word done
            end
            else
            begin
                bit_idx <= bit_idx + bit_index_t'(1);
            end
        end
    end

    // sample pair for the frame that starts now
    always_ff @(posedge clk)
    begin
        if (frame_req)
        begin
            left_q  <= tx_left;
            right_q <= tx_right;
        end
    end

endmodule

// ==== source/sck_divider.sv ====
/*
 * bit clock divider
 *   toggles sck every HALF_SCK_CYCLES system clocks
 *   one-clock strobes on the new high and low levels
 */

`timescale 1ns/1ps
`include "i2s_settings.svh"

module sck_divider
(
    input  logic clk,
    input  logic rst_n,
    output logic sck,
    output logic sck_rise,
    output logic sck_fall
);

    localparam int CNT_W = $clog2(`HALF_SCK_CYCLES);

    logic [CNT_W-1:0] cyc_cnt;      // clocks within the current half period
    logic             half_done;

    assign half_done = (cyc_cnt == CNT_W'(`HALF_SCK_CYCLES - 1));

    //////////////////////////////
    // half period counter and bit clock
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cyc_cnt  <= '0;
            sck      <= 1'b0;
            sck_rise <= 1'b0;
            sck_fall <= 1'b0;
        end
        else
        begin
            // strobe lines up with the clock that sck takes its new level
            sck_rise <= half_done & ~sck;
            sck_fall <= half_done & sck;

            if (half_done)
            begin
                cyc_cnt <= '0;
                sck     <= ~sck;        // toggle bit clock
            end
            else
            begin
                cyc_cnt <= cyc_cnt + CNT_W'(1);
            end
        end
    end

endmodule

// ==== source/i2s_pkg.sv ====
/*
 * I2S types shared by the port
 *   sample_t     one channel word
 *   bit_index_t  position in a word, 0 at the MSB
 *   channel_t    left or right word
 */

`include "i2s_settings.svh"

package i2s_pkg;

    typedef logic [`SAMPLE_BITS-1:0] sample_t;  // one channel sample

    typedef logic [3:0] bit_index_t;            // 0 is the MSB

    // channel of the word on the wire
    typedef enum logic
    {
        CH_LEFT  = 1'b0,
        CH_RIGHT = 1'b1
    } channel_t;

endpackage

// ==== source/i2s_settings.svh ====
/*
 * shared I2S settings
 *   word width per channel
 *   system clocks per half bit clock period
 */

`ifndef I2S_SETTINGS_SVH
`define I2S_SETTINGS_SVH

// bits per channel word, sent MSB first
`define SAMPLE_BITS 16

// half bit clock in system clocks
// 100 MHz / 33 / 2 gives roughly a 1.5 MHz bit clock
`define HALF_SCK_CYCLES 33

`endif
